// ==== pod_pkg.sv ====
package pod_pkg;

  // word and address widths
  localparam int data_width_c = 32;
  localparam int addr_width_c = 8;

  // top address bit picks the north bank when set
  localparam int addr_side_bit_c = addr_width_c - 1;

  // column number, enough for four columns
  localparam int col_width_c = 2;

  // committed tag payload for one side
  typedef struct packed {
    logic reset;
    logic dest_east_not_west;
  } pod_tag_payload_s;

  localparam int tag_payload_width_c = $bits(pod_tag_payload_s);

  // payload value held after rst_i
  localparam pod_tag_payload_s tag_payload_rst_c = '{
    reset: 1'b1,
    dest_east_not_west: 1'b0
  };

  // one write-back record, side bit of addr is always clear
  typedef struct packed {
    logic [col_width_c-1:0]  col;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
  } pod_wb_entry_s;

  localparam int wb_entry_width_c = $bits(pod_wb_entry_s);

endpackage

// ==== pod_link_if.sv ====
`timescale 1ns/100ps

interface pod_link_if
  import pod_pkg::*;
  (
    input logic clk_i
  );

  // request from the tile column
  logic                    req_v;
  logic                    req_we;
  logic [addr_width_c-1:0] req_addr;
  logic [data_width_c-1:0] req_data;

  // response from the bank
  logic                    rsp_v;
  logic [data_width_c-1:0] rsp_data;

  modport tile (
    input  clk_i,
    output req_v, req_we, req_addr, req_data,
    input  rsp_v, rsp_data
  );

  modport bank (
    input  clk_i,
    input  req_v, req_we, req_addr, req_data,
    output rsp_v, rsp_data
  );

endinterface

// ==== pod_tag_client.sv ====
`timescale 1ns/100ps

module pod_tag_client
  import pod_pkg::*;
  (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             tag_en_i,
    input  logic             tag_data_i,
    input  logic             tag_commit_i,
    output pod_tag_payload_s payload_o
  );

  logic [tag_payload_width_c-1:0] shift_r;
  pod_tag_payload_s               payload_r;

  // lsb arrives first and ends up in bit 0
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      shift_r <= '0;
    end else if (tag_en_i) begin
      shift_r <= {tag_data_i, shift_r[tag_payload_width_c-1:1]};
    end
  end

  // commit copies the whole shift register at once
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      payload_r <= tag_payload_rst_c;
    end else if (tag_commit_i) begin
      payload_r <= pod_tag_payload_s'(shift_r);
    end
  end

  assign payload_o = payload_r;

endmodule

// ==== pod_wb_fifo.sv ====
`timescale 1ns/100ps

module pod_wb_fifo
  import pod_pkg::*;
  #(
    parameter int wb_fifo_els_p = 8
  )
  (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          push_i,
    input  pod_wb_entry_s push_entry_i,
    output logic          v_o,
    output pod_wb_entry_s entry_o
  );

  localparam int ptr_width_lp = (wb_fifo_els_p > 1) ? $clog2(wb_fifo_els_p) : 1;
  localparam int cnt_width_lp = $clog2(wb_fifo_els_p + 1);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(wb_fifo_els_p - 1);

  pod_wb_entry_s           mem_r [wb_fifo_els_p];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    pop;

  // drains every cycle it holds something
  assign pop = (count_r != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push_i) begin
        wptr_r <= (wptr_r == last_ptr_lp) ? '0 : wptr_r + 1'b1;
      end
      if (pop) begin
        rptr_r <= (rptr_r == last_ptr_lp) ? '0 : rptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width_lp'(push_i) - cnt_width_lp'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wptr_r] <= push_entry_i;
    end
  end

  assign v_o     = pop;
  assign entry_o = mem_r[rptr_r];

endmodule

// ==== pod_tile_array.sv ====
`timescale 1ns/100ps

module pod_tile_array
  import pod_pkg::*;
  #(
    parameter int num_tiles_x_p = 4
  )
  (
    input  logic                                        clk_i,
    input  logic                                        rst_i,

    input  logic [num_tiles_x_p-1:0]                    req_v_i,
    input  logic [num_tiles_x_p-1:0]                    req_we_i,
    input  logic [num_tiles_x_p-1:0][addr_width_c-1:0]  req_addr_i,
    input  logic [num_tiles_x_p-1:0][data_width_c-1:0]  req_data_i,

    output logic [num_tiles_x_p-1:0]                    rsp_v_o,
    output logic [num_tiles_x_p-1:0][data_width_c-1:0]  rsp_data_o,

    pod_link_if.tile                                    north [num_tiles_x_p],
    pod_link_if.tile                                    south [num_tiles_x_p]
  );

  logic [num_tiles_x_p-1:0]                   req_v_r;
  logic [num_tiles_x_p-1:0]                   req_we_r;
  logic [num_tiles_x_p-1:0][addr_width_c-1:0] req_addr_r;
  logic [num_tiles_x_p-1:0][data_width_c-1:0] req_data_r;

  logic [num_tiles_x_p-1:0]                   n_rsp_v;
  logic [num_tiles_x_p-1:0]                   s_rsp_v;
  logic [num_tiles_x_p-1:0][data_width_c-1:0] n_rsp_data;
  logic [num_tiles_x_p-1:0][data_width_c-1:0] s_rsp_data;

  logic [num_tiles_x_p-1:0]                   rsp_v_r;
  logic [num_tiles_x_p-1:0][data_width_c-1:0] rsp_data_r;

  // request stage
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_v_r <= '0;
    end else begin
      req_v_r <= req_v_i;
    end
    req_we_r   <= req_we_i;
    req_addr_r <= req_addr_i;
    req_data_r <= req_data_i;
  end

  for (genvar i = 0; i < num_tiles_x_p; i++) begin : col
    // route by the side bit
    assign north[i].req_v    = req_v_r[i] & req_addr_r[i][addr_side_bit_c];
    assign north[i].req_we   = req_we_r[i];
    assign north[i].req_addr = req_addr_r[i];
    assign north[i].req_data = req_data_r[i];

    assign south[i].req_v    = req_v_r[i] & ~req_addr_r[i][addr_side_bit_c];
    assign south[i].req_we   = req_we_r[i];
    assign south[i].req_addr = req_addr_r[i];
    assign south[i].req_data = req_data_r[i];

    assign n_rsp_v[i]    = north[i].rsp_v;
    assign n_rsp_data[i] = north[i].rsp_data;
    assign s_rsp_v[i]    = south[i].rsp_v;
    assign s_rsp_data[i] = south[i].rsp_data;
  end

  // response stage, at most one side answers per column per cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_v_r <= '0;
    end else begin
      rsp_v_r <= n_rsp_v | s_rsp_v;
    end
    for (int j = 0; j < num_tiles_x_p; j++) begin
      rsp_data_r[j] <= n_rsp_v[j] ? n_rsp_data[j] : s_rsp_data[j];
    end
  end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_data_o = rsp_data_r;

endmodule

// ==== pod_vcache_row.sv ====
`timescale 1ns/100ps

module pod_vcache_row
  import pod_pkg::*;
  #(
    parameter int num_tiles_x_p = 4,
    parameter int bank_words_p  = 16,
    parameter int wb_fifo_els_p = 8
  )
  (
    input  logic             clk_i,
    input  logic             rst_i,
    input  pod_tag_payload_s payload_i,

    pod_link_if.bank         links [num_tiles_x_p],

    output logic             dma_v_o,
    output logic             dma_east_not_west_o,
    output pod_wb_entry_s    dma_entry_o
  );

  localparam int idx_width_lp = (bank_words_p > 1) ? $clog2(bank_words_p) : 1;

  logic                                       side_rst;
  logic [num_tiles_x_p-1:0]                   req_v;
  logic [num_tiles_x_p-1:0]                   wr_v;
  pod_wb_entry_s                              wr_entry [num_tiles_x_p];
  logic [num_tiles_x_p-1:0]                   rsp_v_r;

  logic [num_tiles_x_p-1:0]                   pend_r;
  pod_wb_entry_s                              pend_entry_r [num_tiles_x_p];
  logic [num_tiles_x_p-1:0]                   pend_clr;
  logic                                       push;
  pod_wb_entry_s                              push_entry;

  assign side_rst = rst_i | payload_i.reset;

  for (genvar i = 0; i < num_tiles_x_p; i++) begin : bank
    logic [data_width_c-1:0] mem_r [bank_words_p];
    logic [data_width_c-1:0] rd_data_r;
    logic [idx_width_lp-1:0] idx;

    assign idx     = links[i].req_addr[idx_width_lp-1:0];
    assign req_v[i] = links[i].req_v & ~side_rst;
    assign wr_v[i]  = req_v[i] & links[i].req_we;

    // bank address with the side bit dropped
    assign wr_entry[i] = '{
      col:  col_width_c'(i),
      addr: {1'b0, links[i].req_addr[addr_side_bit_c-1:0]},
      data: links[i].req_data
    };

    always_ff @(posedge clk_i) begin
      if (wr_v[i]) begin
        mem_r[idx] <= links[i].req_data;
      end
      // writes echo their own data
      rd_data_r <= links[i].req_we ? links[i].req_data : mem_r[idx];
    end

    assign links[i].rsp_v    = rsp_v_r[i];
    assign links[i].rsp_data = rd_data_r;
  end

  always_ff @(posedge clk_i) begin
    if (side_rst) begin
      rsp_v_r <= '0;
      pend_r  <= '0;
    end else begin
      rsp_v_r <= req_v;
      pend_r  <= (pend_r & ~pend_clr) | wr_v;
    end
    for (int j = 0; j < num_tiles_x_p; j++) begin
      if (wr_v[j]) begin
        pend_entry_r[j] <= wr_entry[j];
      end
    end
  end

  // lowest pending column goes first
  always_comb begin
    pend_clr   = '0;
    push       = 1'b0;
    push_entry = pend_entry_r[0];
    for (int j = 0; j < num_tiles_x_p; j++) begin
      if (pend_r[j] && !push) begin
        pend_clr[j] = 1'b1;
        push        = 1'b1;
        push_entry  = pend_entry_r[j];
      end
    end
  end

  pod_wb_fifo #(
    .wb_fifo_els_p(wb_fifo_els_p)
  ) wb_fifo (
    .clk_i       (clk_i),
    .rst_i       (side_rst),
    .push_i      (push),
    .push_entry_i(push_entry),
    .v_o         (dma_v_o),
    .entry_o     (dma_entry_o)
  );

  assign dma_east_not_west_o = payload_i.dest_east_not_west;

endmodule

// ==== manycore_pod.sv ====
`timescale 1ns/100ps

module manycore_pod
  import pod_pkg::*;
  #(
    parameter int num_tiles_x_p = 4,
    parameter int bank_words_p  = 16,
    parameter int wb_fifo_els_p = 8
  )
  (
    input  logic                                        clk_i,
    input  logic                                        rst_i,

    input  logic [num_tiles_x_p-1:0]                    req_v_i,
    input  logic [num_tiles_x_p-1:0]                    req_we_i,
    input  logic [num_tiles_x_p-1:0][addr_width_c-1:0]  req_addr_i,
    input  logic [num_tiles_x_p-1:0][data_width_c-1:0]  req_data_i,
    output logic [num_tiles_x_p-1:0]                    rsp_v_o,
    output logic [num_tiles_x_p-1:0][data_width_c-1:0]  rsp_data_o,

    input  logic                                        north_tag_en_i,
    input  logic                                        north_tag_data_i,
    input  logic                                        north_tag_commit_i,
    input  logic                                        south_tag_en_i,
    input  logic                                        south_tag_data_i,
    input  logic                                        south_tag_commit_i,

    output logic                                        north_dma_v_o,
    output logic                                        north_dma_east_not_west_o,
    output logic [col_width_c-1:0]                      north_dma_col_o,
    output logic [addr_width_c-1:0]                     north_dma_addr_o,
    output logic [data_width_c-1:0]                     north_dma_data_o,

    output logic                                        south_dma_v_o,
    output logic                                        south_dma_east_not_west_o,
    output logic [col_width_c-1:0]                      south_dma_col_o,
    output logic [addr_width_c-1:0]                     south_dma_addr_o,
    output logic [data_width_c-1:0]                     south_dma_data_o
  );

  pod_tag_payload_s north_tag_payload;
  pod_tag_payload_s south_tag_payload;
  pod_wb_entry_s    north_dma_entry;
  pod_wb_entry_s    south_dma_entry;

  pod_link_if north_links [num_tiles_x_p] (.clk_i(clk_i));
  pod_link_if south_links [num_tiles_x_p] (.clk_i(clk_i));

  pod_tag_client north_tag (
    .clk_i(clk_i), .rst_i(rst_i), .tag_en_i(north_tag_en_i), .tag_data_i(north_tag_data_i),
    .tag_commit_i(north_tag_commit_i), .payload_o(north_tag_payload)
  );

  pod_tag_client south_tag (
    .clk_i(clk_i), .rst_i(rst_i), .tag_en_i(south_tag_en_i), .tag_data_i(south_tag_data_i),
    .tag_commit_i(south_tag_commit_i), .payload_o(south_tag_payload)
  );

  pod_tile_array #(.num_tiles_x_p(num_tiles_x_p)) tiles (
    .clk_i(clk_i), .rst_i(rst_i), .req_v_i(req_v_i), .req_we_i(req_we_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .rsp_v_o(rsp_v_o),
    .rsp_data_o(rsp_data_o), .north(north_links), .south(south_links)
  );

  pod_vcache_row #(
    .num_tiles_x_p(num_tiles_x_p), .bank_words_p(bank_words_p), .wb_fifo_els_p(wb_fifo_els_p)
  ) north_vc_row (
    .clk_i(clk_i), .rst_i(rst_i), .payload_i(north_tag_payload), .links(north_links),
    .dma_v_o(north_dma_v_o), .dma_east_not_west_o(north_dma_east_not_west_o),
    .dma_entry_o(north_dma_entry)
  );

  pod_vcache_row #(
    .num_tiles_x_p(num_tiles_x_p), .bank_words_p(bank_words_p), .wb_fifo_els_p(wb_fifo_els_p)
  ) south_vc_row (
    .clk_i(clk_i), .rst_i(rst_i), .payload_i(south_tag_payload), .links(south_links),
    .dma_v_o(south_dma_v_o), .dma_east_not_west_o(south_dma_east_not_west_o),
    .dma_entry_o(south_dma_entry)
  );

  // flatten write-back records onto the edge ports
  assign north_dma_col_o  = north_dma_entry.col;
  assign north_dma_addr_o = north_dma_entry.addr;
  assign north_dma_data_o = north_dma_entry.data;
  assign south_dma_col_o  = south_dma_entry.col;
  assign south_dma_addr_o = south_dma_entry.addr;
  assign south_dma_data_o = south_dma_entry.data;

endmodule

// ==== manycore_pod_sva.sv ====
`timescale 1ns/100ps

module manycore_pod_sva #(
    parameter int num_tiles_x_p = 4
  )
  (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic [num_tiles_x_p-1:0] req_v_i,
    input logic [num_tiles_x_p-1:0] rsp_v_o,
    input logic                     north_dma_v_o,
    input logic                     south_dma_v_o
  );

  int assert_fails = 0;

  // each response goes back to a request three cycles earlier
  rsp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_v_o & ~$past(req_v_i, 3)) == '0)
    else begin
      $error("response on a column with no request three cycles before");
      assert_fails++;
    end

  dma_quiet_in_reset: assert property (@(posedge clk_i)
    (rst_i && $past(rst_i)) |-> !(north_dma_v_o || south_dma_v_o))
    else begin
      $error("write-back strobe while the pod is in reset");
      assert_fails++;
    end

  rsp_quiet_in_reset: assert property (@(posedge clk_i)
    (rst_i && $past(rst_i)) |-> (rsp_v_o == '0))
    else begin
      $error("response strobe while the pod is in reset");
      assert_fails++;
    end

endmodule

bind manycore_pod manycore_pod_sva #(.num_tiles_x_p(num_tiles_x_p)) pod_checks (
  .clk_i(clk_i), .rst_i(rst_i), .req_v_i(req_v_i), .rsp_v_o(rsp_v_o),
  .north_dma_v_o(north_dma_v_o), .south_dma_v_o(south_dma_v_o)
);

// ==== tb_manycore_pod.sv ====
`timescale 1ns/100ps

module tb_manycore_pod
  import pod_pkg::*;
  ();

  localparam int cols_lp    = 4;
  localparam int steps_lp   = 24;
  localparam int timeout_lp = 40;

  typedef struct packed {
    logic [1:0]  col;
    logic        side;
    logic        we;
    logic [6:0]  word;
    logic [31:0] data;
    logic [31:0] exp;
  } step_s;

  logic                                  clk_i;
  logic                                  rst_i;
  logic [cols_lp-1:0]                    req_v_i;
  logic [cols_lp-1:0]                    req_we_i;
  logic [cols_lp-1:0][addr_width_c-1:0]  req_addr_i;
  logic [cols_lp-1:0][data_width_c-1:0]  req_data_i;
  logic [cols_lp-1:0]                    rsp_v_o;
  logic [cols_lp-1:0][data_width_c-1:0]  rsp_data_o;
  logic                                  north_tag_en_i;
  logic                                  north_tag_data_i;
  logic                                  north_tag_commit_i;
  logic                                  south_tag_en_i;
  logic                                  south_tag_data_i;
  logic                                  south_tag_commit_i;
  logic                                  north_dma_v_o;
  logic                                  north_dma_east_not_west_o;
  logic [col_width_c-1:0]                north_dma_col_o;
  logic [addr_width_c-1:0]               north_dma_addr_o;
  logic [data_width_c-1:0]               north_dma_data_o;
  logic                                  south_dma_v_o;
  logic                                  south_dma_east_not_west_o;
  logic [col_width_c-1:0]                south_dma_col_o;
  logic [addr_width_c-1:0]               south_dma_addr_o;
  logic [data_width_c-1:0]               south_dma_data_o;

  step_s         steps [steps_lp];
  logic [31:0]   shadow [2][cols_lp][16];
  pod_wb_entry_s north_wb_q [$];
  pod_wb_entry_s south_wb_q [$];
  logic          exp_dir [2];
  int            seed = 99106;
  int            errors = 0;
  int            timeouts = 0;

  manycore_pod uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic drive_req(input int col, input logic we, input logic [7:0] addr,
                           input logic [31:0] data);
    req_v_i[col]    <= 1'b1;
    req_we_i[col]   <= we;
    req_addr_i[col] <= addr;
    req_data_i[col] <= data;
  endtask

  task automatic clear_req();
    req_v_i  <= '0;
    req_we_i <= '0;
  endtask

  task automatic push_wb(input logic side, input int col, input logic [6:0] word,
                         input logic [31:0] data);
    pod_wb_entry_s e;
    e.col  = 2'(col);
    e.addr = {1'b0, word};
    e.data = data;
    if (side) begin
      north_wb_q.push_back(e);
    end else begin
      south_wb_q.push_back(e);
    end
  endtask

  // latency counted in cycles from the edge that drove the request
  task automatic await_rsp(input logic [cols_lp-1:0] mask, output int lat);
    lat = -1;
    @(posedge clk_i);
    clear_req();
    for (int k = 1; k <= timeout_lp && lat < 0; k++) begin
      @(negedge clk_i);
      if ((rsp_v_o & mask) == mask) begin
        lat = k;
      end
    end
    if (lat < 0) begin
      $display("timed out waiting for a response on columns %b", mask);
      timeouts++;
    end
  endtask

  task automatic expect_no_rsp(input logic [cols_lp-1:0] mask);
    logic seen;
    seen = 1'b0;
    @(posedge clk_i);
    clear_req();
    for (int k = 1; k <= timeout_lp; k++) begin
      @(negedge clk_i);
      seen = seen | ((rsp_v_o & mask) != '0);
    end
    if (seen) begin
      $display("a side held in reset answered a request");
      errors++;
    end
  endtask

  task automatic await_drain();
    logic empty;
    empty = 1'b0;
    for (int k = 0; k < timeout_lp && !empty; k++) begin
      @(negedge clk_i);
      empty = (north_wb_q.size() == 0) && (south_wb_q.size() == 0);
    end
    if (!empty) begin
      $display("timed out waiting for the write-back queues to drain");
      timeouts++;
    end
  endtask

  task automatic check_rsp(input int col, input logic [31:0] exp, input int lat);
    if (lat > 0) begin
      check_value("rsp_latency", 64'(3), 64'(lat));
      check_value($sformatf("rsp_data_o[%0d]", col), exp, rsp_data_o[col]);
    end
  endtask

  task automatic run_request(input int col, input logic side, input logic we,
                             input logic [6:0] word, input logic [31:0] data,
                             input logic [31:0] exp);
    int lat;
    @(posedge clk_i);
    drive_req(col, we, {side, word}, data);
    if (we) begin
      push_wb(side, col, word, data);
    end
    await_rsp(cols_lp'(1) << col, lat);
    check_rsp(col, exp, lat);
  endtask

  // bits go in lsb first, then one commit pulse
  task automatic load_tag(input logic side, input logic r, input logic dest);
    pod_tag_payload_s               p;
    logic [tag_payload_width_c-1:0] bits;
    p.reset              = r;
    p.dest_east_not_west = dest;
    bits                 = p;
    for (int i = 0; i < tag_payload_width_c; i++) begin
      @(posedge clk_i);
      if (side) begin
        north_tag_en_i   <= 1'b1;
        north_tag_data_i <= bits[i];
      end else begin
        south_tag_en_i   <= 1'b1;
        south_tag_data_i <= bits[i];
      end
    end
    @(posedge clk_i);
    north_tag_en_i     <= 1'b0;
    south_tag_en_i     <= 1'b0;
    north_tag_commit_i <= side;
    south_tag_commit_i <= ~side;
    @(posedge clk_i);
    north_tag_commit_i <= 1'b0;
    south_tag_commit_i <= 1'b0;
    exp_dir[side] = dest;
  endtask

  task automatic add_step(input int n, input int col, input logic side, input logic we,
                          input int word, input logic [31:0] data);
    steps[n].col  = 2'(col);
    steps[n].side = side;
    steps[n].we   = we;
    steps[n].word = 7'(word);
    steps[n].data = data;
    if (we) begin
      shadow[side][col][word] = data;
    end
    steps[n].exp = shadow[side][col][word];
  endtask

  task automatic build_table();
    logic [31:0] d;
    logic [31:0] d2;
    int          n;
    int          c;
    n = 0;
    for (int i = 0; i < cols_lp; i++) begin
      d     = $random(seed);
      d2    = $random(seed);
      // same low address on both sides, top bit forced apart
      d2[31] = ~d[31];
      add_step(n, i, 1'b1, 1'b1, i + 2, d);
      add_step(n + 1, i, 1'b0, 1'b1, i + 2, d2);
      n += 2;
    end
    for (int i = 0; i < cols_lp; i++) begin
      add_step(n, i, 1'b1, 1'b0, i + 2, '0);
      add_step(n + 1, i, 1'b0, 1'b0, i + 2, '0);
      n += 2;
    end
    while (n < steps_lp) begin
      d = $random(seed);
      c = int'(d[3:2]);
      add_step(n, c, d[0], d[1], c + 2, $random(seed));
      n++;
    end
  endtask

  task automatic write_all_cols(input logic side);
    logic [31:0] d [cols_lp];
    int          lat;
    @(posedge clk_i);
    for (int c = 0; c < cols_lp; c++) begin
      d[c]                 = $random(seed);
      shadow[side][c][8 + c] = d[c];
      drive_req(c, 1'b1, {side, 7'(8 + c)}, d[c]);
      push_wb(side, c, 7'(8 + c), d[c]);
    end
    await_rsp('1, lat);
    for (int c = 0; c < cols_lp; c++) begin
      check_rsp(c, d[c], lat);
    end
  endtask

  task automatic check_wb(input logic side, input pod_wb_entry_s got, input logic dir);
    pod_wb_entry_s exp;
    string         row;
    row = side ? "north" : "south";
    if ((side ? north_wb_q.size() : south_wb_q.size()) == 0) begin
      $display("the %s row sent a write-back that no write caused", row);
      errors++;
    end else begin
      if (side) begin
        exp = north_wb_q.pop_front();
      end else begin
        exp = south_wb_q.pop_front();
      end
      check_value({row, "_dma_col_o"}, 64'(exp.col), 64'(got.col));
      check_value({row, "_dma_addr_o"}, 64'(exp.addr), 64'(got.addr));
      check_value({row, "_dma_data_o"}, 64'(exp.data), 64'(got.data));
      check_value({row, "_dma_east_not_west_o"}, 64'(exp_dir[side]), 64'(dir));
    end
  endtask

  // write-back monitor, entries must match the expected order
  always @(negedge clk_i) begin
    if (north_dma_v_o === 1'b1) begin
      check_wb(1'b1, {north_dma_col_o, north_dma_addr_o, north_dma_data_o},
               north_dma_east_not_west_o);
    end
    if (south_dma_v_o === 1'b1) begin
      check_wb(1'b0, {south_dma_col_o, south_dma_addr_o, south_dma_data_o},
               south_dma_east_not_west_o);
    end
  end

  initial begin
    rst_i              = 1'b1;
    req_v_i            = '0;
    req_we_i           = '0;
    req_addr_i         = '0;
    req_data_i         = '0;
    north_tag_en_i     = 1'b0;
    north_tag_data_i   = 1'b0;
    north_tag_commit_i = 1'b0;
    south_tag_en_i     = 1'b0;
    south_tag_data_i   = 1'b0;
    south_tag_commit_i = 1'b0;
    exp_dir[0]         = 1'b0;
    exp_dir[1]         = 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    // no tag loaded yet, both rows still held
    @(posedge clk_i);
    drive_req(0, 1'b1, 8'h82, 32'h1234_5678);
    drive_req(1, 1'b1, 8'h03, 32'h8765_4321);
    expect_no_rsp('1);

    load_tag(1'b1, 1'b0, 1'b0);
    load_tag(1'b0, 1'b0, 1'b0);
    for (int i = 0; i < steps_lp; i++) begin
      run_request(steps[i].col, steps[i].side, steps[i].we, steps[i].word,
                  steps[i].data, steps[i].exp);
    end
    await_drain();

    write_all_cols(1'b1);
    write_all_cols(1'b0);
    await_drain();

    // north write-back turns east
    load_tag(1'b1, 1'b0, 1'b1);
    shadow[1][1][12] = $random(seed);
    run_request(1, 1'b1, 1'b1, 7'd12, shadow[1][1][12], shadow[1][1][12]);
    await_drain();

    // south back into reset, north keeps answering
    load_tag(1'b0, 1'b1, 1'b0);
    @(posedge clk_i);
    drive_req(2, 1'b0, 8'h04, '0);
    expect_no_rsp(4'b0100);
    run_request(1, 1'b1, 1'b0, 7'd12, '0, shadow[1][1][12]);
    run_request(3, 1'b1, 1'b0, 7'd5, '0, shadow[1][3][5]);
    await_drain();

    errors += uut.pod_checks.assert_fails;
    $display("errors: %0d timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
pod_pkg.sv
pod_link_if.sv
pod_tag_client.sv
pod_wb_fifo.sv
pod_tile_array.sv
pod_vcache_row.sv
manycore_pod.sv
manycore_pod_sva.sv
tb_manycore_pod.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_manycore_pod
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
